// ==== verilog/corePkg.sv ====
`default_nettype none

package corePkg;

    localparam int xlen = 64;
    localparam int shamtW = $clog2(xlen);

    localparam logic [xlen-1:0] resetPc = 64'h0000_0000_8000_0000;
    localparam logic [31:0] ebreakInst = 32'h0010_0073; // full ebreak encoding

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluXor,
        aluOr,
        aluAnd,
        aluSll,
        aluSrl,
        aluSlt,
        aluSltu,
        aluPassB, // lui
        aluMul,   // low 32 bits only
        aluDivu,  // low 32 bits only
        aluRem,   // low 32 bits, signed
        aluNone
    } aluOpE;

    typedef enum logic [1:0] {
        wbAlu,
        wbMem,
        wbPcPlus4,
        wbAluWord // low word of alu result, sign-extended
    } wbSelE;

    typedef enum logic [2:0] {
        fmtI,
        fmtS,
        fmtB,
        fmtU,
        fmtJ
    } immFmtE;

    typedef enum logic [6:0] {
        opLoad    = 7'b0000011,
        opOpImm   = 7'b0010011,
        opAuipc   = 7'b0010111,
        opOpImm32 = 7'b0011011,
        opStore   = 7'b0100011,
        opOp      = 7'b0110011,
        opLui     = 7'b0110111,
        opOp32    = 7'b0111011,
        opBranch  = 7'b1100011,
        opJalr    = 7'b1100111,
        opJal     = 7'b1101111,
        opSystem  = 7'b1110011
    } opcodeE;

    typedef struct packed {
        aluOpE       aluOp;
        logic        selA;         // 1 rs1, 0 pc
        logic        selB;         // 1 rs2, 0 imm
        logic        regWrite;
        wbSelE       wbSel;
        logic        memRead;
        logic [7:0]  memWriteMask; // unshifted byte mask
        logic [3:0]  loadBytes;    // 1, 2, 4 or 8
        logic        loadSigned;
        logic        jumpReg;      // jalr
        immFmtE      immFmt;
    } ctrlT;

endpackage

`default_nettype wire

// ==== verilog/immGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module immGen (
    input  logic [31:0]               inst,
    input  corePkg::immFmtE           immFmt,
    output logic [corePkg::xlen-1:0]  imm
);
    import corePkg::*;

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (immFmt)
            fmtI: imm = {{(xlen-12){sign}}, inst[31:20]};
            fmtS: imm = {{(xlen-12){sign}}, inst[31:25], inst[11:7]};
            fmtB: begin
                imm = {{(xlen-13){sign}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            fmtU: imm = {{(xlen-32){sign}}, inst[31:12], 12'h000};
            fmtJ: begin
                imm = {{(xlen-21){sign}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/aluUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluUnit (
    input  logic [corePkg::xlen-1:0]  opA,
    input  logic [corePkg::xlen-1:0]  opB,
    input  corePkg::aluOpE            aluOp,
    output logic [corePkg::xlen-1:0]  result
);
    import corePkg::*;

    logic [31:0] wordA;
    logic [31:0] wordB;
    logic [31:0] mulLo;
    logic [31:0] divuLo;
    logic [31:0] remLo;
    logic [shamtW-1:0] shamt;

    assign wordA = opA[31:0];
    assign wordB = opB[31:0];
    assign shamt = opB[shamtW-1:0];

    assign mulLo = wordA * wordB; // only low word kept

    // divide by zero per ISA
    assign divuLo = (wordB == 32'h0) ? 32'hffff_ffff : wordA / wordB;

    always_comb begin
        if (wordB == 32'h0) begin
            remLo = wordA;
        end else if (wordB == 32'hffff_ffff) begin
            remLo = 32'h0; // also covers the signed overflow case
        end else begin
            remLo = 32'($signed(wordA) % $signed(wordB));
        end
    end

    always_comb begin
        case (aluOp)
            aluAdd:   result = opA + opB;
            aluSub:   result = opA - opB;
            aluXor:   result = opA ^ opB;
            aluOr:    result = opA | opB;
            aluAnd:   result = opA & opB;
            aluSll:   result = opA << shamt;
            aluSrl:   result = opA >> shamt;
            aluSlt:   result = xlen'($signed(opA) < $signed(opB));
            aluSltu:  result = xlen'(opA < opB);
            aluPassB: result = opB;
            aluMul:   result = {{(xlen-32){1'b0}}, mulLo};
            aluDivu:  result = {{(xlen-32){1'b0}}, divuLo};
            aluRem:   result = {{(xlen-32){1'b0}}, remLo};
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/regFile.sv ====
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic [4:0]                rs1Addr,
    input  logic [4:0]                rs2Addr,
    input  logic [4:0]                rdAddr,
    input  logic                      rdWrite,
    input  logic [corePkg::xlen-1:0]  rdData,
    output logic [corePkg::xlen-1:0]  rs1Data,
    output logic [corePkg::xlen-1:0]  rs2Data
);
    import corePkg::*;

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdWrite && (rdAddr != 5'd0)) begin
            regs[rdAddr] <= rdData; // x0 writes dropped
        end
    end

    assign rs1Data = (rs1Addr == 5'd0) ? '0 : regs[rs1Addr];
    assign rs2Data = (rs2Addr == 5'd0) ? '0 : regs[rs2Addr];

endmodule

`default_nettype wire

// ==== verilog/loadStoreUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

module loadStoreUnit (
    input  logic [corePkg::xlen-1:0]  addr,
    input  logic [corePkg::xlen-1:0]  storeData,
    input  corePkg::ctrlT             ctrl,
    input  logic [corePkg::xlen-1:0]  dataRdata,
    output logic [corePkg::xlen-1:0]  dataAddr,
    output logic [corePkg::xlen-1:0]  dataWdata,
    output logic [7:0]                dataWmask,
    output logic                      dataWen,
    output logic                      dataRen,
    output logic [corePkg::xlen-1:0]  loadData
);
    import corePkg::*;

    logic [2:0] byteOff;
    logic [xlen-1:0] laneData;
    logic extBit;
    logic [3:0] accessBytes;

    assign byteOff = addr[2:0];
    assign dataAddr = {addr[xlen-1:3], 3'b000}; // doubleword lane

    assign dataWmask = ctrl.memWriteMask << byteOff;
    assign dataWdata = storeData << {byteOff, 3'b000};
    assign dataWen = |dataWmask;
    assign dataRen = ctrl.memRead;

    assign laneData = dataRdata >> {byteOff, 3'b000};

    always_comb begin
        case (ctrl.loadBytes)
            4'd1: extBit = ctrl.loadSigned & laneData[7];
            4'd2: extBit = ctrl.loadSigned & laneData[15];
            default: extBit = ctrl.loadSigned & laneData[31];
        endcase
        case (ctrl.loadBytes)
            4'd1: loadData = {{(xlen-8){extBit}}, laneData[7:0]};
            4'd2: loadData = {{(xlen-16){extBit}}, laneData[15:0]};
            4'd4: loadData = {{(xlen-32){extBit}}, laneData[31:0]};
            default: loadData = laneData;
        endcase
    end

    assign accessBytes = ctrl.memRead ? ctrl.loadBytes : 4'($countones(ctrl.memWriteMask));

    always_comb begin
        if ((dataWen || dataRen) && !$isunknown(addr)) begin
            assert final (({1'b0, byteOff} & (accessBytes - 4'd1)) == 4'd0)
                else $error("misaligned access at %h", addr);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/instDecoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instDecoder (
    input  logic [31:0]               inst,
    input  logic [corePkg::xlen-1:0]  rs1Data,
    input  logic [corePkg::xlen-1:0]  rs2Data,
    output corePkg::ctrlT             ctrl,
    output logic                      branchTaken,
    output logic                      halt
);
    import corePkg::*;

    opcodeE opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = opcodeE'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    // imm forms ignore funct7 except for shifts
    function automatic aluOpE opAlu(input logic [2:0] f3, input logic [6:0] f7, input logic isImm);
        aluOpE op;
        logic plain;
        logic shiftOk;
        plain = isImm || (f7 == 7'h00);
        shiftOk = isImm ? (f7[6:1] == 6'h00) : (f7 == 7'h00);
        case (f3)
            3'b000: op = plain ? aluAdd : ((f7 == 7'h20) ? aluSub : aluNone);
            3'b001: op = shiftOk ? aluSll : aluNone;
            3'b010: op = plain ? aluSlt : aluNone;
            3'b011: op = plain ? aluSltu : aluNone;
            3'b100: op = plain ? aluXor : aluNone;
            3'b101: op = shiftOk ? aluSrl : aluNone; // no sra
            3'b110: op = plain ? aluOr : aluNone;
            default: op = plain ? aluAnd : aluNone;
        endcase
        return op;
    endfunction

    assign halt = (inst == ebreakInst);

    always_comb begin
        ctrl = '0;
        ctrl.aluOp = aluNone;
        ctrl.selA = 1'b1;
        ctrl.selB = 1'b1;
        ctrl.wbSel = wbAlu;
        ctrl.loadBytes = 4'd8;
        ctrl.immFmt = fmtI;
        branchTaken = 1'b0;
        case (opcode)
            opOp: begin
                ctrl.aluOp = opAlu(funct3, funct7, 1'b0);
                ctrl.regWrite = (ctrl.aluOp != aluNone);
            end
            opOpImm: begin
                ctrl.selB = 1'b0;
                ctrl.aluOp = opAlu(funct3, funct7, 1'b1);
                ctrl.regWrite = (ctrl.aluOp != aluNone);
            end
            opOp32: begin
                ctrl.wbSel = wbAluWord;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrl.aluOp = aluAdd;  // addw
                    {7'h01, 3'b000}: ctrl.aluOp = aluMul;  // mulw
                    {7'h01, 3'b101}: ctrl.aluOp = aluDivu; // divuw
                    {7'h01, 3'b110}: ctrl.aluOp = aluRem;  // remw
                    default: ctrl.aluOp = aluNone;
                endcase
                ctrl.regWrite = (ctrl.aluOp != aluNone);
            end
            opOpImm32: begin
                ctrl.selB = 1'b0;
                ctrl.wbSel = wbAluWord;
                ctrl.aluOp = (funct3 == 3'b000) ? aluAdd : aluNone; // addiw only
                ctrl.regWrite = (funct3 == 3'b000);
            end
            opLui: begin
                ctrl.selB = 1'b0;
                ctrl.immFmt = fmtU;
                ctrl.aluOp = aluPassB;
                ctrl.regWrite = 1'b1;
            end
            opAuipc: begin
                ctrl.selA = 1'b0;
                ctrl.selB = 1'b0;
                ctrl.immFmt = fmtU;
                ctrl.aluOp = aluAdd;
                ctrl.regWrite = 1'b1;
            end
            opJal: begin
                ctrl.selA = 1'b0; // alu forms pc + imm
                ctrl.selB = 1'b0;
                ctrl.immFmt = fmtJ;
                ctrl.aluOp = aluAdd;
                ctrl.wbSel = wbPcPlus4;
                ctrl.regWrite = 1'b1;
            end
            opJalr: begin
                ctrl.selB = 1'b0;
                ctrl.aluOp = aluAdd;
                ctrl.wbSel = (funct3 == 3'b000) ? wbPcPlus4 : wbAlu;
                ctrl.jumpReg = (funct3 == 3'b000);
                ctrl.regWrite = (funct3 == 3'b000);
            end
            opBranch: begin
                ctrl.selA = 1'b0;
                ctrl.selB = 1'b0;
                ctrl.immFmt = fmtB;
                ctrl.aluOp = aluAdd; // target address
                case (funct3)
                    3'b000: branchTaken = (rs1Data == rs2Data);
                    3'b001: branchTaken = (rs1Data != rs2Data);
                    3'b100: branchTaken = ($signed(rs1Data) < $signed(rs2Data));
                    3'b101: branchTaken = ($signed(rs1Data) >= $signed(rs2Data));
                    3'b110: branchTaken = (rs1Data < rs2Data);
                    3'b111: branchTaken = (rs1Data >= rs2Data);
                    default: branchTaken = 1'b0;
                endcase
            end
            opLoad: begin
                ctrl.selB = 1'b0;
                ctrl.aluOp = aluAdd;
                ctrl.wbSel = wbMem;
                ctrl.memRead = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.loadSigned = !funct3[2];
                case (funct3)
                    3'b000, 3'b100: ctrl.loadBytes = 4'd1;
                    3'b001, 3'b101: ctrl.loadBytes = 4'd2;
                    3'b010: ctrl.loadBytes = 4'd4;
                    3'b011: ctrl.loadBytes = 4'd8;
                    default: begin
                        ctrl.memRead = 1'b0; // lwu and friends not supported
                        ctrl.regWrite = 1'b0;
                    end
                endcase
            end
            opStore: begin
                ctrl.selB = 1'b0;
                ctrl.immFmt = fmtS;
                ctrl.aluOp = aluAdd;
                case (funct3)
                    3'b000: ctrl.memWriteMask = 8'h01;
                    3'b001: ctrl.memWriteMask = 8'h03;
                    3'b010: ctrl.memWriteMask = 8'h0f;
                    3'b011: ctrl.memWriteMask = 8'hff;
                    default: ctrl.memWriteMask = 8'h00;
                endcase
            end
            default: ; // ebreak and unknown encodings do nothing
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/rvCore.sv ====
`timescale 1ns/10ps
`default_nettype none

module rvCore (
    input  logic                      clk,
    input  logic                      arstN,
    output logic [corePkg::xlen-1:0]  instAddr,
    input  logic [31:0]               inst,
    output logic [corePkg::xlen-1:0]  dataAddr,
    output logic [corePkg::xlen-1:0]  dataWdata,
    output logic [7:0]                dataWmask,
    output logic                      dataWen,
    output logic                      dataRen,
    input  logic [corePkg::xlen-1:0]  dataRdata,
    output logic                      halt
);
    import corePkg::*;

    ctrlT ctrl;
    logic branchTaken;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] nextPc;
    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] loadData;
    logic [xlen-1:0] wbData;

    instDecoder decoder_i (.inst, .rs1Data, .rs2Data, .ctrl, .branchTaken, .halt);

    immGen immGen_i (.inst, .immFmt(ctrl.immFmt), .imm);

    regFile regFile_i (
        .clk, .arstN,
        .rs1Addr(inst[19:15]), .rs2Addr(inst[24:20]), .rdAddr(inst[11:7]),
        .rdWrite(ctrl.regWrite), .rdData(wbData),
        .rs1Data, .rs2Data
    );

    assign opA = ctrl.selA ? rs1Data : pc;
    assign opB = ctrl.selB ? rs2Data : imm;

    aluUnit alu_i (.opA, .opB, .aluOp(ctrl.aluOp), .result(aluResult));

    loadStoreUnit lsu_i (
        .addr(aluResult), .storeData(rs2Data), .ctrl, .dataRdata,
        .dataAddr, .dataWdata, .dataWmask, .dataWen, .dataRen, .loadData
    );

    assign pcPlus4 = pc + xlen'(4);

    always_comb begin
        case (ctrl.wbSel)
            wbMem:     wbData = loadData;
            wbPcPlus4: wbData = pcPlus4;
            wbAluWord: wbData = {{(xlen-32){aluResult[31]}}, aluResult[31:0]};
            default:   wbData = aluResult;
        endcase
    end

    // alu already holds pc + imm for jal and branches, rs1 + imm for jalr
    always_comb begin
        if (halt) begin
            nextPc = pc;
        end else if (ctrl.jumpReg) begin
            nextPc = {aluResult[xlen-1:1], 1'b0};
        end else if ((ctrl.wbSel == wbPcPlus4) || branchTaken) begin
            nextPc = aluResult;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

    assign instAddr = pc;

    pcAligned: assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
        else $error("pc not word aligned");

endmodule

`default_nettype wire

// ==== dv/coreTbModel.svh ====
`ifndef coreTbModelSvh
`define coreTbModelSvh

// ISA reference model, one instruction per step
logic [63:0] mRegs [32];
logic [63:0] mPc;
logic        mHalted;
logic [63:0] mMem [logic [63:0]]; // sparse, keyed by doubleword address
logic        mWen;
logic        mRen;
logic [63:0] mWaddr;
logic [7:0]  mWmask;
logic [63:0] mWdata;

// initial memory contents, a function of the whole address
function automatic logic [63:0] fillWord(input logic [63:0] addr);
    return {addr[63:32] ^ (addr[31:0] * 32'h9e37_79b9), addr[31:0] * 32'h85eb_ca6b};
endfunction

function automatic logic [63:0] peekMem(input logic [63:0] addr);
    logic [63:0] key;
    key = {addr[63:3], 3'b000};
    return mMem.exists(key) ? mMem[key] : fillWord(key);
endfunction

function automatic logic [63:0] sext32(input logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

task automatic resetModel();
    for (int i = 0; i < 32; i++) begin
        mRegs[i] = '0;
    end
    mPc = resetPc;
    mHalted = 1'b0;
    mWen = 1'b0;
    mRen = 1'b0;
    mMem.delete();
endtask

task automatic stepModel(input logic [31:0] in);
    logic [6:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [4:0] rd;
    logic [63:0] a, b, iImm, sImm, bImm, uImm, jImm;
    logic [63:0] res, addr, word, npc;
    logic wr;
    logic taken;
    op = in[6:0];
    f3 = in[14:12];
    f7 = in[31:25];
    rd = in[11:7];
    a = mRegs[in[19:15]];
    b = mRegs[in[24:20]];
    iImm = {{52{in[31]}}, in[31:20]};
    sImm = {{52{in[31]}}, in[31:25], in[11:7]};
    bImm = {{51{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
    uImm = {{32{in[31]}}, in[31:12], 12'h000};
    jImm = {{43{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
    npc = mPc + 64'd4;
    wr = 1'b0;
    res = '0;
    taken = 1'b0;
    mWen = 1'b0;
    mRen = 1'b0;
    if (mHalted) begin
        return;
    end
    case (op)
        7'h33, 7'h13: begin
            wr = 1'b1;
            if (op == 7'h13) begin
                b = iImm;
            end
            case (f3)
                3'd0: res = (op == 7'h33 && f7[5]) ? a - b : a + b;
                3'd1: res = a << b[5:0];
                3'd2: res = {63'h0, $signed(a) < $signed(b)};
                3'd3: res = {63'h0, a < b};
                3'd4: res = a ^ b;
                3'd5: res = a >> b[5:0];
                3'd6: res = a | b;
                default: res = a & b;
            endcase
        end
        7'h3b: begin
            wr = 1'b1;
            case ({f7[0], f3})
                4'b0000: res = sext32(a[31:0] + b[31:0]);
                4'b1000: res = sext32(a[31:0] * b[31:0]);
                4'b1101: res = sext32((b[31:0] == 0) ? 32'hffff_ffff : a[31:0] / b[31:0]);
                default: begin
                    if (b[31:0] == 0) res = sext32(a[31:0]);
                    else if (b[31:0] == 32'hffff_ffff) res = '0; // remainder by -1
                    else res = sext32(32'($signed(a[31:0]) % $signed(b[31:0])));
                end
            endcase
        end
        7'h1b: begin
            wr = 1'b1;
            res = sext32(a[31:0] + iImm[31:0]);
        end
        7'h37: begin
            wr = 1'b1;
            res = uImm;
        end
        7'h17: begin
            wr = 1'b1;
            res = mPc + uImm;
        end
        7'h6f: begin
            wr = 1'b1;
            res = mPc + 64'd4;
            npc = mPc + jImm;
        end
        7'h67: begin
            wr = 1'b1;
            res = mPc + 64'd4;
            npc = (a + iImm) & ~64'd1;
        end
        7'h63: begin
            case (f3)
                3'd0: taken = (a == b);
                3'd1: taken = (a != b);
                3'd4: taken = ($signed(a) < $signed(b));
                3'd5: taken = ($signed(a) >= $signed(b));
                3'd6: taken = (a < b);
                default: taken = (a >= b);
            endcase
            if (taken) npc = mPc + bImm;
        end
        7'h03: begin
            wr = 1'b1;
            mRen = 1'b1;
            addr = a + iImm;
            word = peekMem(addr) >> (8 * addr[2:0]);
            case (f3)
                3'd0: res = {{56{word[7]}}, word[7:0]};
                3'd1: res = {{48{word[15]}}, word[15:0]};
                3'd2: res = {{32{word[31]}}, word[31:0]};
                3'd4: res = {56'h0, word[7:0]};
                3'd5: res = {48'h0, word[15:0]};
                default: res = word;
            endcase
        end
        7'h23: begin
            addr = a + sImm;
            mWen = 1'b1;
            mWaddr = {addr[63:3], 3'b000};
            mWmask = 8'((1 << (1 << f3[1:0])) - 1) << addr[2:0];
            mWdata = b << (8 * addr[2:0]);
            word = peekMem(addr);
            for (int i = 0; i < 8; i++) begin
                if (mWmask[i]) word[8*i +: 8] = mWdata[8*i +: 8];
            end
            mMem[mWaddr] = word;
        end
        default: begin
            if (in == 32'h0010_0073) begin // ebreak
                mHalted = 1'b1;
                npc = mPc;
            end
        end
    endcase
    if (wr && rd != 5'd0) mRegs[rd] = res;
    mPc = npc;
endtask

`endif

// ==== dv/coreTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module coreTb;
    import corePkg::*;

    localparam int progLen = 240;
    localparam int runLimit = 1000;
    localparam int holdCycles = 20;

    logic        clk;
    logic        arstN;
    logic [63:0] instAddr;
    logic [31:0] inst;
    logic [63:0] dataAddr;
    logic [63:0] dataWdata;
    logic [63:0] dataRdata;
    logic [7:0]  dataWmask;
    logic        dataWen;
    logic        dataRen;
    logic        halt;

    logic [31:0] imem [progLen];
    logic [63:0] dmem [512]; // 4 KB window 0x1800..0x27ff
    int checks;
    int errors;
    int baseChecks;
    int baseErrors;

    `include "coreTbModel.svh"

    rvCore dut_i (.*);

    always #50 clk = ~clk;

    assign dataRdata = dmem[dataAddr[11:3]];

    always @(posedge clk) begin
        if (arstN && dataWen) begin
            for (int i = 0; i < 8; i++) begin
                if (dataWmask[i]) dmem[dataAddr[11:3]][8*i +: 8] <= dataWdata[8*i +: 8];
            end
        end
    end

    function automatic logic [31:0] fetchWord(input logic [63:0] addr);
        logic [63:0] idx;
        idx = (addr - resetPc) >> 2;
        return (idx < progLen) ? imem[idx] : 32'h0010_0073;
    endfunction

    task automatic compareValue(input string what, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic beginTest();
        baseChecks = checks;
        baseErrors = errors;
    endtask

    task automatic reportTest(input string name);
        $display("test %s: %0d checks, %0d failed", name, checks - baseChecks, errors - baseErrors);
    endtask

    task automatic fillDataMem();
        logic [63:0] base;
        for (int i = 0; i < 512; i++) begin
            base = (i < 256) ? 64'h2000 : 64'h1000;
            dmem[i] = fillWord(base + 64'(8 * i));
        end
    endtask

    task automatic buildProgram();
        int slot;
        logic [4:0] rd, rs1, rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        logic [20:0] off;
        logic pairStore;
        imem[0] = {20'h00000, 5'd31, 7'h17}; // x31 = program base, jalr anchor
        imem[1] = {20'h00002, 5'd1, 7'h37};  // x1 = data window centre
        slot = 2;
        while (slot < progLen - 8) begin
            rd = ($urandom_range(0, 7) == 0) ? 5'd0 : 5'($urandom_range(2, 30));
            rs1 = 5'($urandom_range(0, 31));
            rs2 = 5'($urandom_range(0, 31));
            f3 = 3'($urandom_range(0, 7));
            imm = 12'($urandom);
            off = 21'(4 * $urandom_range(1, 4)); // short forward hop
            pairStore = 1'($urandom_range(0, 1));
            case ($urandom_range(0, 9))
                0: begin
                    f7 = (f3 == 3'd0 && $urandom_range(0, 1) == 1) ? 7'h20 : 7'h00;
                    imem[slot] = {f7, rs2, rs1, f3, rd, 7'h33};
                end
                1: begin
                    if (f3 == 3'd1 || f3 == 3'd5) imm[11:6] = '0;
                    imem[slot] = {imm, rs1, f3, rd, 7'h13};
                end
                2: begin
                    case ($urandom_range(0, 3))
                        0: {f7, f3} = {7'h00, 3'd0};
                        1: {f7, f3} = {7'h01, 3'd0};
                        2: {f7, f3} = {7'h01, 3'd5};
                        default: {f7, f3} = {7'h01, 3'd6};
                    endcase
                    imem[slot] = {f7, rs2, rs1, f3, rd, 7'h3b};
                end
                3: imem[slot] = {imm, rs1, 3'd0, rd, 7'h1b};
                4: imem[slot] = {imm, 8'($urandom), rd, ($urandom_range(0, 1) == 1) ? 7'h37 : 7'h17};
                5: begin
                    f3 = 3'($urandom_range(0, 5));
                    imm = imm & ~12'((1 << f3[1:0]) - 1);
                    imem[slot] = {imm, 5'd1, f3, rd, 7'h03};
                    pairStore = 1'b1; // always expose loaded value
                end
                6: begin
                    f3 = 3'($urandom_range(0, 3));
                    imm = imm & ~12'((1 << f3[1:0]) - 1);
                    imem[slot] = {imm[11:5], rs2, 5'd1, f3, imm[4:0], 7'h23};
                    pairStore = 1'b0;
                end
                7: imem[slot] = {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
                8: begin
                    f3 = 3'($urandom_range(0, 5));
                    if (f3 > 3'd1) f3 = f3 + 3'd2;
                    imem[slot] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
                    pairStore = 1'b0;
                end
                default: begin
                    imm = 12'(4 * (slot + $urandom_range(1, 4)) + $urandom_range(0, 1));
                    imem[slot] = {imm, 5'd31, 3'd0, rd, 7'h67};
                end
            endcase
            slot++;
            if (pairStore) begin
                imm = 12'($urandom) & ~12'h007;
                imem[slot] = {imm[11:5], rd, 5'd1, 3'd3, imm[4:0], 7'h23}; // sd rd
                slot++;
            end
        end
        while (slot < progLen) begin
            imem[slot] = 32'h0010_0073;
            slot++;
        end
    endtask

    initial begin
        int cycles;
        logic [63:0] heldPc;
        void'($urandom(32'h5dd2_7217)); // seed once
        clk = 1'b0;
        arstN = 1'b0;
        inst = '0;
        checks = 0;
        errors = 0;
        buildProgram();
        fillDataMem();
        resetModel();
        repeat (3) @(negedge clk);
        arstN = 1'b1;

        beginTest();
        compareValue("pc after reset", instAddr, resetPc);
        compareValue("store enable after reset", dataWen, 1'b0);
        compareValue("halt after reset", halt, 1'b0);
        reportTest("reset");

        beginTest();
        cycles = 0;
        while (!mHalted && cycles < runLimit) begin
            compareValue("pc", instAddr, mPc);
            inst = fetchWord(instAddr);
            #10;
            stepModel(inst);
            compareValue("store enable", dataWen, mWen);
            compareValue("load enable", dataRen, mRen);
            compareValue("halt", halt, mHalted);
            if (mWen) begin
                compareValue("store address", dataAddr, mWaddr);
                compareValue("store mask", dataWmask, mWmask);
                compareValue("store data", dataWdata, mWdata);
            end
            @(negedge clk);
            cycles++;
        end
        if (!mHalted) begin
            $display("timeout: program did not reach ebreak within %0d cycles", runLimit);
            errors++;
        end
        reportTest("program");

        if (mHalted) begin
            beginTest();
            heldPc = mPc;
            for (int i = 0; i < holdCycles; i++) begin
                compareValue("halted pc", instAddr, heldPc);
                inst = fetchWord(instAddr);
                #10;
                compareValue("halt level", halt, 1'b1);
                compareValue("store enable while halted", dataWen, 1'b0);
                @(negedge clk);
            end
            reportTest("halt");
        end

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+dv
verilog/corePkg.sv
verilog/immGen.sv
verilog/aluUnit.sv
verilog/regFile.sv
verilog/loadStoreUnit.sv
verilog/instDecoder.sv
verilog/rvCore.sv
dv/coreTb.sv
